// ==== common/qspi_pkg.sv ====
`default_nettype none

package qspi_pkg;

	////////////////////////////////////////
	// Requester commands and FSM states

	typedef enum logic [0:0] {
		CMD_READ,
		CMD_QUAD_READ
	} flash_cmd_t;

	// Sequencer steps, one shifter byte per step
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_OPCODE,
		SEQ_ADDR_HI,
		SEQ_ADDR_MID,
		SEQ_ADDR_LO,
		SEQ_DUMMY,
		SEQ_DATA,
		SEQ_ACK
	} seq_state_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_BUSY,
		ARB_RELEASE
	} arb_state_t;

	////////////////////////////////////////
	// Data types and flash constants

	typedef logic [23:0] flash_addr_t;
	typedef logic [7:0]  flash_byte_t;

	localparam flash_byte_t OPCODE_READ      = 8'h03;
	localparam flash_byte_t OPCODE_QUAD_READ = 8'h6b;

	// clk cycles per SCK half period are this value plus one
	localparam logic [14:0] SCK_HALF_CYCLES = 15'd2;

	// Minimum chip select high time between reads
	localparam int unsigned CS_IDLE_CYCLES = 4;

endpackage

`default_nettype wire

// ==== qspi_phy/qspi_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module qspi_shifter (
	input  wire                        clk,
	input  wire                        rst_n,

	// Byte requests from the sequencer
	input  wire                        shift_en,
	input  wire                        quad_shift_en,
	input  wire qspi_pkg::flash_byte_t tx_data,
	output logic                       shift_done,
	output qspi_pkg::flash_byte_t      rx_data,

	// Flash pins
	output logic                       qspi_sck,
	output logic [3:0]                 qspi_dq_out,
	output logic [3:0]                 qspi_dq_oe,
	input  wire  [3:0]                 qspi_dq_in
);
	import qspi_pkg::*;

	////////////////////////////////////////
	// Half period timing

	logic        active;
	logic        quad_active;
	logic [14:0] clk_count;
	logic        toggle;

	// One SCK edge every SCK_HALF_CYCLES+1 cycles while a byte runs
	assign toggle = active && (clk_count >= SCK_HALF_CYCLES);

	////////////////////////////////////////
	// Bit engine

	// Rising edges seen so far, in bits
	logic [3:0] bit_count;

	// Remaining tx bits after the first one went out at start
	logic [6:0] tx_shreg;
	logic [7:0] rx_shreg;

	// Byte is complete and stable by the time shift_done fires
	assign rx_data = rx_shreg;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active      <= 1'b0;
			quad_active <= 1'b0;
			clk_count   <= '0;
			bit_count   <= '0;
			tx_shreg    <= '0;
			rx_shreg    <= '0;
			shift_done  <= 1'b0;
			qspi_sck    <= 1'b0;
			qspi_dq_out <= 4'b0000;
			qspi_dq_oe  <= 4'b0000;
		end else begin
			shift_done <= 1'b0;

			// Start an x1 byte, MSB goes out right away on DQ0
			if (shift_en) begin
				active      <= 1'b1;
				quad_active <= 1'b0;
				clk_count   <= '0;
				bit_count   <= '0;
				qspi_sck    <= 1'b0;
				qspi_dq_oe  <= 4'b0001;
				qspi_dq_out <= {3'b000, tx_data[7]};
				tx_shreg    <= tx_data[6:0];
			end

			// Start a quad receive byte, all lines released
			else if (quad_shift_en) begin
				active      <= 1'b1;
				quad_active <= 1'b1;
				clk_count   <= '0;
				bit_count   <= '0;
				qspi_sck    <= 1'b0;
				qspi_dq_oe  <= 4'b0000;
				qspi_dq_out <= 4'b0000;
				tx_shreg    <= '0;
			end

			else if (active) begin
				clk_count <= clk_count + 15'd1;

				if (toggle) begin
					clk_count <= '0;

					// Falling edge, put the next bit on DQ0
					if (qspi_sck) begin
						qspi_sck    <= 1'b0;
						qspi_dq_out <= {3'b000, tx_shreg[6]};
						tx_shreg    <= {tx_shreg[5:0], 1'b0};
					end

					// Closing half period is over
					else if (bit_count == 4'd8) begin
						active      <= 1'b0;
						quad_active <= 1'b0;
						shift_done  <= 1'b1;
					end

					// Rising edge, sample just before SCK goes high
					else begin
						qspi_sck <= 1'b1;
						if (quad_active) begin
							bit_count <= bit_count + 4'd4;
							rx_shreg  <= {rx_shreg[3:0], qspi_dq_in};
						end else begin
							bit_count <= bit_count + 4'd1;
							rx_shreg  <= {rx_shreg[6:0], qspi_dq_in[1]};
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/qspi_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module qspi_arbiter (
	input  wire                        clk,
	input  wire                        rst_n,

	// Requester ports
	input  wire                        req0,
	input  wire                        req1,
	input  wire qspi_pkg::flash_cmd_t  cmd0,
	input  wire qspi_pkg::flash_cmd_t  cmd1,
	input  wire qspi_pkg::flash_addr_t addr0,
	input  wire qspi_pkg::flash_addr_t addr1,
	output logic                       ack0,
	output logic                       ack1,
	output qspi_pkg::flash_byte_t      rdata0,
	output qspi_pkg::flash_byte_t      rdata1,

	// Single request path to the sequencer
	output logic                       seq_req,
	output qspi_pkg::flash_cmd_t       seq_cmd,
	output qspi_pkg::flash_addr_t      seq_addr,
	input  wire                        seq_ack,
	input  wire qspi_pkg::flash_byte_t seq_rdata
);
	import qspi_pkg::*;

	arb_state_t state;

	// One-hot grant, zero while idle
	logic [1:0] grant;
	logic       last_served;
	logic       pick;
	logic       granted_req;

	// Port 1 wins a tie only when port 0 was served last
	assign pick        = (req0 && req1) ? !last_served : req1;
	assign granted_req = (grant[0] && req0) || (grant[1] && req1);

	// Request follows the granted port directly so ack drops one cycle after req
	assign seq_req = (state == ARB_BUSY) && granted_req;

	// Response goes to the granted port only
	assign ack0   = seq_ack && grant[0];
	assign ack1   = seq_ack && grant[1];
	assign rdata0 = grant[0] ? seq_rdata : '0;
	assign rdata1 = grant[1] ? seq_rdata : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= ARB_IDLE;
			grant       <= 2'b00;
			last_served <= 1'b1;
		end else begin
			case (state)
				ARB_IDLE: if (req0 || req1) begin
					grant       <= pick ? 2'b10 : 2'b01;
					last_served <= pick;
					state       <= ARB_BUSY;
				end
				ARB_BUSY: if (!granted_req) state <= ARB_RELEASE;
				ARB_RELEASE: if (!seq_ack) begin
					grant <= 2'b00;
					state <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Command and address captured at grant, held for the whole read
	always_ff @(posedge clk) begin
		if (state == ARB_IDLE && (req0 || req1)) begin
			seq_cmd  <= pick ? cmd1 : cmd0;
			seq_addr <= pick ? addr1 : addr0;
		end
	end

endmodule

`default_nettype wire

// ==== source/flash_read_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module flash_read_sequencer (
	input  wire                        clk,
	input  wire                        rst_n,

	// Request path from the arbiter
	input  wire                        seq_req,
	input  wire qspi_pkg::flash_cmd_t  seq_cmd,
	input  wire qspi_pkg::flash_addr_t seq_addr,
	output logic                       seq_ack,
	output qspi_pkg::flash_byte_t      seq_rdata,

	// Chip select to the pin
	output logic                       qspi_cs_n,

	// Byte strobes to the shifter
	output logic                       shift_en,
	output logic                       quad_shift_en,
	output qspi_pkg::flash_byte_t      tx_data,
	input  wire                        shift_done,
	input  wire qspi_pkg::flash_byte_t rx_data
);
	import qspi_pkg::*;

	seq_state_t state;
	logic [2:0] idle_count;
	logic       idle_ok;
	logic       is_quad;

	assign idle_ok = (idle_count >= 3'(CS_IDLE_CYCLES));
	assign is_quad = (seq_cmd == CMD_QUAD_READ);

	////////////////////////////////////////
	// Chip select idle time

	// Counts up while cs_n is high, saturates once the gap is long enough
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idle_count <= '0;
		end else if (!qspi_cs_n) begin
			idle_count <= '0;
		end else if (!idle_ok) begin
			idle_count <= idle_count + 3'd1;
		end
	end

	////////////////////////////////////////
	// Byte framing

	// Strobe goes out on entry to a state, so tx_data follows the state
	always_comb begin
		case (state)
			SEQ_OPCODE:   tx_data = is_quad ? OPCODE_QUAD_READ : OPCODE_READ;
			SEQ_ADDR_HI:  tx_data = seq_addr[23:16];
			SEQ_ADDR_MID: tx_data = seq_addr[15:8];
			SEQ_ADDR_LO:  tx_data = seq_addr[7:0];
			default:      tx_data = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= SEQ_IDLE;
			seq_ack       <= 1'b0;
			qspi_cs_n     <= 1'b1;
			shift_en      <= 1'b0;
			quad_shift_en <= 1'b0;
		end else begin
			shift_en      <= 1'b0;
			quad_shift_en <= 1'b0;
			case (state)
				// Open the frame and send the opcode
				SEQ_IDLE: if (seq_req && idle_ok) begin
					qspi_cs_n <= 1'b0;
					shift_en  <= 1'b1;
					state     <= SEQ_OPCODE;
				end
				SEQ_OPCODE: if (shift_done) begin
					shift_en <= 1'b1;
					state    <= SEQ_ADDR_HI;
				end
				SEQ_ADDR_HI: if (shift_done) begin
					shift_en <= 1'b1;
					state    <= SEQ_ADDR_MID;
				end
				SEQ_ADDR_MID: if (shift_done) begin
					shift_en <= 1'b1;
					state    <= SEQ_ADDR_LO;
				end
				// Quad read needs 8 dummy clocks, done as one zero byte
				SEQ_ADDR_LO: if (shift_done) begin
					shift_en <= 1'b1;
					state    <= is_quad ? SEQ_DUMMY : SEQ_DATA;
				end
				SEQ_DUMMY: if (shift_done) begin
					quad_shift_en <= 1'b1;
					state         <= SEQ_DATA;
				end
				SEQ_DATA: if (shift_done) begin
					qspi_cs_n <= 1'b1;
					state     <= SEQ_ACK;
				end
				// Ack one cycle after cs_n rises, hold it until req drops
				SEQ_ACK: begin
					if (!seq_ack) begin
						seq_ack <= 1'b1;
					end else if (!seq_req) begin
						seq_ack <= 1'b0;
						state   <= SEQ_IDLE;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Read byte, valid from the ack onward
	always_ff @(posedge clk) begin
		if (state == SEQ_DATA && shift_done) seq_rdata <= rx_data;
	end

endmodule

`default_nettype wire

// ==== source/qspi_flash_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module qspi_flash_top (
	input  wire                        clk,
	input  wire                        rst_n,

	// Requester port 0
	input  wire                        req0,
	input  wire qspi_pkg::flash_cmd_t  cmd0,
	input  wire qspi_pkg::flash_addr_t addr0,
	output logic                       ack0,
	output qspi_pkg::flash_byte_t      rdata0,

	// Requester port 1
	input  wire                        req1,
	input  wire qspi_pkg::flash_cmd_t  cmd1,
	input  wire qspi_pkg::flash_addr_t addr1,
	output logic                       ack1,
	output qspi_pkg::flash_byte_t      rdata1,

	// Flash pins
	output logic                       qspi_sck,
	output logic                       qspi_cs_n,
	output logic [3:0]                 qspi_dq_out,
	output logic [3:0]                 qspi_dq_oe,
	input  wire  [3:0]                 qspi_dq_in
);
	import qspi_pkg::*;

	// Arbiter to sequencer
	logic        seq_req;
	flash_cmd_t  seq_cmd;
	flash_addr_t seq_addr;
	logic        seq_ack;
	flash_byte_t seq_rdata;

	// Sequencer to shifter
	logic        shift_en;
	logic        quad_shift_en;
	logic        shift_done;
	flash_byte_t tx_data;
	flash_byte_t rx_data;

	qspi_arbiter arbiter_i (
		.clk, .rst_n, .req0, .req1, .cmd0, .cmd1, .addr0, .addr1,
		.ack0, .ack1, .rdata0, .rdata1, .seq_req, .seq_cmd, .seq_addr,
		.seq_ack, .seq_rdata
	);

	flash_read_sequencer sequencer_i (
		.clk, .rst_n, .seq_req, .seq_cmd, .seq_addr, .seq_ack, .seq_rdata,
		.qspi_cs_n, .shift_en, .quad_shift_en, .tx_data, .shift_done, .rx_data
	);

	qspi_shifter shifter_i (
		.clk, .rst_n, .shift_en, .quad_shift_en, .tx_data, .shift_done, .rx_data,
		.qspi_sck, .qspi_dq_out, .qspi_dq_oe, .qspi_dq_in
	);

endmodule

`default_nettype wire

// ==== verif/qspi_flash_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module qspi_flash_checker (
	input wire                        clk,
	input wire                        rst_n,
	input wire                        ack0,
	input wire                        ack1,
	input wire                        qspi_sck,
	input wire                        qspi_cs_n,
	input wire [3:0]                  qspi_dq_oe,
	input wire qspi_pkg::seq_state_t  seq_state,
	input wire qspi_pkg::flash_cmd_t  seq_cmd
);
	import qspi_pkg::*;

	// Cycles with cs_n high since it last rose
	int unsigned high_count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// Reset counts as a long idle gap
			high_count <= CS_IDLE_CYCLES;
		end else if (qspi_cs_n) begin
			high_count <= high_count + 1;
		end else begin
			high_count <= 0;
		end
	end

	////////////////////////////////////////
	// Protocol rules

	// Only one port gets a response at a time
	one_ack: assert property (@(posedge clk) disable iff (!rst_n) !(ack0 && ack1))
		else $error("ack0 and ack1 are high together");

	// SPI mode 0, clock parked low outside a frame
	sck_idle: assert property (@(posedge clk) disable iff (!rst_n) qspi_cs_n |-> !qspi_sck)
		else $error("SCK high while chip select is inactive");

	// First cycle of the data state still shows the dummy byte enables
	quad_hiz: assert property (@(posedge clk) disable iff (!rst_n)
		(seq_state == SEQ_DATA && $past(seq_state) == SEQ_DATA &&
		 seq_cmd == CMD_QUAD_READ && !qspi_cs_n) |-> (qspi_dq_oe == 4'b0000))
		else $error("DQ lines driven during the quad data byte");

	cs_gap: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(qspi_cs_n) |-> (high_count >= CS_IDLE_CYCLES))
		else $error("chip select idle gap too short");

endmodule

bind qspi_flash_top qspi_flash_checker checker_i (
	.clk, .rst_n, .ack0, .ack1, .qspi_sck, .qspi_cs_n, .qspi_dq_oe,
	.seq_state(sequencer_i.state), .seq_cmd
);

`default_nettype wire

// ==== verif/qspi_flash_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module qspi_flash_tb;
	import qspi_pkg::*;

	localparam int N_FIXED   = 5;
	localparam int N_ENTRIES = 15;
	// Two reads per entry at most and six bytes per read
	localparam int CYCLE_LIMIT = N_ENTRIES * 2 * 6 * 17 * (int'(SCK_HALF_CYCLES) + 1) + 200;

	typedef struct packed {
		logic [1:0]  mask;
		flash_cmd_t  cmd0;
		flash_addr_t addr0;
		flash_cmd_t  cmd1;
		flash_addr_t addr1;
	} entry_t;

	logic        clk;
	logic        rst_n;
	logic        req0, req1;
	flash_cmd_t  cmd0, cmd1;
	flash_addr_t addr0, addr1;
	logic        ack0, ack1;
	flash_byte_t rdata0, rdata1;
	logic        qspi_sck, qspi_cs_n;
	logic [3:0]  qspi_dq_out, qspi_dq_oe, qspi_dq_in;

	entry_t      stim_table [N_ENTRIES];
	logic [31:0] lfsr_state = 32'h9650_256b;
	int          cycle_count = 0;
	int          last_port = 1;

	qspi_flash_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	// Flash contents are the XOR of the address bytes and 5Ah
	function automatic flash_byte_t memory_byte(input flash_addr_t a);
		return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
	endfunction

	task automatic report_failure(input string msg);
		$display("%0t: %s", $time, msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input flash_byte_t got, input flash_byte_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %02h expected %02h", $time, name, got, exp);
			report_failure("byte mismatch");
		end
	endtask

	task automatic check_addr(input string name, input flash_addr_t got, input flash_addr_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %06h expected %06h", $time, name, got, exp);
			report_failure("address mismatch");
		end
	endtask

	task automatic check_cmd(input string name, input flash_cmd_t got, input flash_cmd_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
			report_failure("command mismatch");
		end
	endtask

	////////////////////////////////////////
	// Flash model

	logic [7:0]  fm_opcode;
	flash_addr_t fm_addr;
	flash_byte_t fm_data;
	int          fm_rises = 0;
	int          fm_falls = 0;
	flash_byte_t seen_op_q [$];
	flash_addr_t seen_addr_q [$];
	int          seen_rises_q [$];

	always @(negedge qspi_cs_n) begin
		fm_rises  = 0;
		fm_falls  = 0;
		fm_opcode = '0;
		fm_addr   = '0;
	end

	// Opcode then address come MSB first on DQ0
	always @(posedge qspi_sck) begin
		if (!qspi_cs_n) begin
			fm_rises++;
			if (fm_rises <= 8) fm_opcode = {fm_opcode[6:0], qspi_dq_out[0]};
			else if (fm_rises <= 32) fm_addr = {fm_addr[22:0], qspi_dq_out[0]};
			if (fm_rises == 8 && fm_opcode != OPCODE_READ && fm_opcode != OPCODE_QUAD_READ)
				report_failure("flash model got an unknown opcode");
			if (fm_rises == 32) fm_data = memory_byte(fm_addr);
		end
	end

	// Response bits change on the falling edge
	always @(negedge qspi_sck) begin
		if (!qspi_cs_n) begin
			fm_falls++;
			if (fm_opcode == OPCODE_READ && fm_falls >= 32 && fm_falls < 40)
				qspi_dq_in <= {2'b00, fm_data[39 - fm_falls], 1'b0};
			// Quad nibbles follow 8 dummy clocks with the high nibble first
			else if (fm_opcode == OPCODE_QUAD_READ && fm_falls == 40)
				qspi_dq_in <= fm_data[7:4];
			else if (fm_opcode == OPCODE_QUAD_READ && fm_falls == 41)
				qspi_dq_in <= fm_data[3:0];
			else
				qspi_dq_in <= 4'b0000;
		end
	end

	always @(posedge qspi_cs_n) begin
		if (rst_n && fm_rises > 0) begin
			seen_op_q.push_back(fm_opcode);
			seen_addr_q.push_back(fm_addr);
			seen_rises_q.push_back(fm_rises);
			qspi_dq_in <= 4'b0000;
		end
	end

	////////////////////////////////////////
	// Handshake monitor and timeout

	logic ack0_d = 1'b0, ack1_d = 1'b0, req0_d = 1'b0, req1_d = 1'b0;

	always @(posedge clk) begin
		if (rst_n) begin
			if (ack0 && !ack0_d && !req0) report_failure("ack0 rose while req0 was low");
			if (ack1 && !ack1_d && !req1) report_failure("ack1 rose while req1 was low");
			if (ack0_d && !ack0 && req0_d) report_failure("ack0 fell while req0 was high");
			if (ack1_d && !ack1 && req1_d) report_failure("ack1 fell while req1 was high");
		end
		ack0_d <= ack0;
		ack1_d <= ack1;
		req0_d <= req0;
		req1_d <= req1;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) report_failure("timeout, a read never completed");
	end

	////////////////////////////////////////
	// Stimulus

	// Wait for the port's ack and check it before finishing the four-phase handshake
	task automatic serve_port(input int port, input entry_t e);
		flash_addr_t a;
		flash_cmd_t  c;
		flash_byte_t op;
		int          rises;
		int          exp_rises;
		a = (port == 1) ? e.addr1 : e.addr0;
		c = (port == 1) ? e.cmd1 : e.cmd0;
		@(posedge clk);
		while (!((port == 1) ? ack1 : ack0)) begin
			if ((port == 1) ? ack0 : ack1) report_failure("ack on the port that was not granted");
			@(posedge clk);
		end
		if (port == 1) check_byte("rdata1", rdata1, memory_byte(a));
		else check_byte("rdata0", rdata0, memory_byte(a));
		if (seen_addr_q.size() == 0) report_failure("flash model saw no transaction");
		op    = seen_op_q.pop_front();
		rises = seen_rises_q.pop_front();
		check_addr("flash address", seen_addr_q.pop_front(), a);
		check_cmd("flash command", (op == OPCODE_QUAD_READ) ? CMD_QUAD_READ : CMD_READ, c);
		// 32 clocks of header plus 8 dummy and 2 nibble clocks for quad
		exp_rises = (c == CMD_QUAD_READ) ? 42 : 40;
		if (rises != exp_rises) begin
			$display("Fail at %0t: qspi_sck rises got %0d expected %0d", $time, rises, exp_rises);
			report_failure("wrong SCK count in one transaction");
		end
		if (port == 1) req1 <= 1'b0;
		else req0 <= 1'b0;
		@(posedge clk);
		while ((port == 1) ? ack1 : ack0) @(posedge clk);
	endtask

	initial begin
		logic [31:0] r;
		int          first;
		rst_n      = 1'b0;
		req0       = 1'b0;
		req1       = 1'b0;
		cmd0       = CMD_READ;
		cmd1       = CMD_READ;
		addr0      = '0;
		addr1      = '0;
		qspi_dq_in = 4'b0000;

		// Directed entries first
		stim_table[0] = '{2'b01, CMD_READ, 24'h12_3456, CMD_READ, 24'h00_0000};
		stim_table[1] = '{2'b10, CMD_READ, 24'h00_0000, CMD_QUAD_READ, 24'h00_abcd};
		stim_table[2] = '{2'b11, CMD_READ, 24'h0f_0f0f, CMD_QUAD_READ, 24'hf0_f0f0};
		stim_table[3] = '{2'b11, CMD_QUAD_READ, 24'h80_0001, CMD_READ, 24'h7f_fffe};
		stim_table[4] = '{2'b10, CMD_READ, 24'h00_0000, CMD_READ, 24'hff_ffff};
		for (int i = N_FIXED; i < N_ENTRIES; i++) begin
			r = draw_bits(2);
			stim_table[i].mask = (r[1:0] == 2'b00) ? 2'b01 : r[1:0];
			r = draw_bits(1);
			stim_table[i].cmd0 = flash_cmd_t'(r[0]);
			r = draw_bits(24);
			stim_table[i].addr0 = r[23:0];
			r = draw_bits(1);
			stim_table[i].cmd1 = flash_cmd_t'(r[0]);
			r = draw_bits(24);
			stim_table[i].addr1 = r[23:0];
		end

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		for (int i = 0; i < N_ENTRIES; i++) begin
			@(posedge clk);
			if (stim_table[i].mask[0]) begin
				req0  <= 1'b1;
				cmd0  <= stim_table[i].cmd0;
				addr0 <= stim_table[i].addr0;
			end
			if (stim_table[i].mask[1]) begin
				req1  <= 1'b1;
				cmd1  <= stim_table[i].cmd1;
				addr1 <= stim_table[i].addr1;
			end
			// Tie goes to the port not served last
			if (stim_table[i].mask == 2'b11) begin
				first = (last_port == 1) ? 0 : 1;
				serve_port(first, stim_table[i]);
				serve_port(1 - first, stim_table[i]);
				last_port = 1 - first;
			end else begin
				first = stim_table[i].mask[1] ? 1 : 0;
				serve_port(first, stim_table[i]);
				last_port = first;
			end
		end

		repeat (4) @(posedge clk);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
common/qspi_pkg.sv
qspi_phy/qspi_shifter.sv
source/qspi_arbiter.sv
source/flash_read_sequencer.sv
source/qspi_flash_top.sv
verif/qspi_flash_checker.sv
verif/qspi_flash_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module qspi_flash_tb -f compile.f

# A failing run still prints its output before the search
output=$(./obj_dir/Vqspi_flash_tb || true)
echo "$output"
echo "$output" | grep -q "RESULT: PASS"
